//--- include/mips_config.svh
// widths, reset PC and instruction field positions for the MIPS core; include where needed
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`define MIPS_WORD_W     32            // data and address width
`define MIPS_REG_ADDR_W 5             // register number width
`define MIPS_REG_COUNT  32            // architectural registers
`define MIPS_RESET_PC   32'h0000_0000 // first fetch address

`define MIPS_OPCODE_W   6             // instr[31:26]
`define MIPS_FUNCT_W    6             // instr[5:0], R-type only
`define MIPS_IMM_W      16            // instr[15:0], I-type
`define MIPS_JUMP_W     26            // instr[25:0], j

`define MIPS_OP_LSB     26            // opcode field start
`define MIPS_RS_LSB     21            // rs field start
`define MIPS_RT_LSB     16            // rt field start
`define MIPS_RD_LSB     11            // rd field start
`endif

//--- rtl/mipsPkg.sv
// types shared by the MIPS core RTL and its testbench; import with mipsPkg::*
`default_nettype none
`include "mips_config.svh"

package mipsPkg;

  typedef logic [`MIPS_WORD_W-1:0]     word_t;    // data or byte address
  typedef logic [`MIPS_REG_ADDR_W-1:0] regAddr_t; // register number

  typedef enum logic [`MIPS_OPCODE_W-1:0] {
    opRtype = 6'b000000,
    opJ     = 6'b000010,
    opBeq   = 6'b000100,
    opAddi  = 6'b001000,
    opLw    = 6'b100011,
    opSw    = 6'b101011
  } opcode_t;

  typedef enum logic [`MIPS_FUNCT_W-1:0] {
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    fnSlt = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluCtrl_t;

  typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm, srcBImmSh} aluSrcB_t;
  typedef enum logic [1:0] {pcAluResult, pcAluOut, pcJump} pcSrc_t;

  typedef enum logic [3:0] {
    sFetch, sDecode, sMemAdr, sMemRd, sMemWb, sMemWr,
    sRtypeEx, sRtypeWb, sBeqEx, sAddiEx, sAddiWb, sJumpEx
  } cpuState_t;

endpackage

`default_nettype wire

//--- rtl/ctrlIf.sv
// control strobes and selects from the control FSM to the PC unit and the datapath
`default_nettype none
`timescale 1ns/1ps

interface ctrlIf import mipsPkg::*; ();
  logic     pcWrite;  // unconditional pc load
  logic     branch;   // pc load when alu zero
  pcSrc_t   pcSrc;    // next pc source
  logic     irWrite;  // latch fetched word
  logic     regWrite; // register file write
  logic     iorD;     // memory address from aluOut instead of pc
  logic     memToReg; // write back memory data
  logic     regDst;   // write rd instead of rt
  logic     aluSrcA;  // alu a from register A instead of pc
  aluSrcB_t aluSrcB;
  aluCtrl_t aluCtrl;

  modport fsm (output pcWrite, branch, pcSrc, irWrite, regWrite, iorD,
               memToReg, regDst, aluSrcA, aluSrcB, aluCtrl);
  modport pc  (input pcWrite, branch, pcSrc);
  modport dp  (input irWrite, regWrite, iorD, memToReg, regDst, aluSrcA,
               aluSrcB, aluCtrl);
endinterface

`default_nettype wire

//--- rtl/alu.sv
// behavioural ALU for the MIPS core; and, or, add, sub and signed slt with a zero flag
`default_nettype none
`timescale 1ns/1ps

module alu import mipsPkg::*; (
  input  word_t    a,
  input  word_t    b,
  input  aluCtrl_t op,
  output word_t    y,
  output logic     zero // y is all zeros, beq compare
);
  logic lessThan;

  assign lessThan = $signed(a) < $signed(b); // two's complement compare

  always_comb begin
    case (op)
      aluAnd:  y = a & b;
      aluOr:   y = a | b;
      aluAdd:  y = a + b; // wraps, no overflow trap
      aluSub:  y = a - b;
      aluSlt:  y = word_t'(lessThan); // zero extended
      default: y = '0;
    endcase
  end

  assign zero = (y == '0);

endmodule

`default_nettype wire

//--- rtl/regFile.sv
// MIPS register file, two combinational reads and one clocked write, r0 reads as zero
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module regFile import mipsPkg::*; (
  input  logic     clk,
  input  logic     we,
  input  regAddr_t ra1,
  input  regAddr_t ra2,
  input  regAddr_t wa,
  input  word_t    wd,
  output word_t    rd1,
  output word_t    rd2
);
  word_t regs [`MIPS_REG_COUNT]; // r0 may be written but never read back

  always_ff @(posedge clk) begin
    if (we) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 != '0) ? regs[ra1] : '0; // r0 hardwired to zero
  assign rd2 = (ra2 != '0) ? regs[ra2] : '0;

endmodule

`default_nettype wire

//--- rtl/controlFsm.sv
// multicycle control FSM with main and ALU decode; drives ctrlIf and the memory write strobe
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module controlFsm import mipsPkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t instr,   // from instruction register
  ctrlIf.fsm    ctl,
  output logic  memWrite // memory write strobe, sMemWr only
);
  cpuState_t state, nextState;
  opcode_t   op;
  funct_t    funct;

  assign op    = opcode_t'(instr[`MIPS_OP_LSB +: `MIPS_OPCODE_W]);
  assign funct = funct_t'(instr[`MIPS_FUNCT_W-1:0]);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= sFetch;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    case (state)
      sFetch:   nextState = sDecode;
      sDecode: begin
        case (op)
          opLw, opSw: nextState = sMemAdr;
          opRtype:    nextState = sRtypeEx;
          opBeq:      nextState = sBeqEx;
          opAddi:     nextState = sAddiEx;
          opJ:        nextState = sJumpEx;
          default:    nextState = sFetch; // unsupported, treated as no-op
        endcase
      end
      sMemAdr:  nextState = (op == opLw) ? sMemRd : sMemWr;
      sMemRd:   nextState = sMemWb;
      sRtypeEx: nextState = sRtypeWb;
      sAddiEx:  nextState = sAddiWb;
      default:  nextState = sFetch; // writebacks, sMemWr, sBeqEx, sJumpEx
    endcase
  end

  always_comb begin
    ctl.pcWrite  = 1'b0;
    ctl.branch   = 1'b0;
    ctl.pcSrc    = pcAluResult;
    ctl.irWrite  = 1'b0;
    ctl.regWrite = 1'b0;
    ctl.iorD     = 1'b0;
    ctl.memToReg = 1'b0;
    ctl.regDst   = 1'b0;
    ctl.aluSrcA  = 1'b0;
    ctl.aluSrcB  = srcBReg;
    ctl.aluCtrl  = aluAdd; // address, pc and addi arithmetic
    memWrite     = 1'b0;
    case (state)
      sFetch: begin
        ctl.irWrite = 1'b1;
        ctl.pcWrite = 1'b1;     // pc + 4 straight from alu
        ctl.aluSrcB = srcBFour;
      end
      sDecode:  ctl.aluSrcB = srcBImmSh; // branch target into aluOut
      sMemAdr: begin
        ctl.aluSrcA = 1'b1;
        ctl.aluSrcB = srcBImm;
      end
      sMemRd:   ctl.iorD = 1'b1;
      sMemWb: begin
        ctl.memToReg = 1'b1;
        ctl.regWrite = 1'b1;
      end
      sMemWr: begin
        ctl.iorD = 1'b1;
        memWrite = 1'b1;
      end
      sRtypeEx: begin
        ctl.aluSrcA = 1'b1;
        case (funct)
          fnSub:   ctl.aluCtrl = aluSub;
          fnAnd:   ctl.aluCtrl = aluAnd;
          fnOr:    ctl.aluCtrl = aluOr;
          fnSlt:   ctl.aluCtrl = aluSlt;
          default: ctl.aluCtrl = aluAdd; // fnAdd and unknown functs
        endcase
      end
      sRtypeWb: begin
        ctl.regDst   = 1'b1;
        ctl.regWrite = 1'b1;
      end
      sBeqEx: begin
        ctl.aluSrcA = 1'b1;
        ctl.aluCtrl = aluSub;   // zero flag means equal
        ctl.branch  = 1'b1;
        ctl.pcSrc   = pcAluOut; // target held since decode
      end
      sAddiEx: begin
        ctl.aluSrcA = 1'b1;
        ctl.aluSrcB = srcBImm;
      end
      sAddiWb:  ctl.regWrite = 1'b1; // rt gets aluOut
      sJumpEx: begin
        ctl.pcWrite = 1'b1;
        ctl.pcSrc   = pcJump;
      end
      default: ;
    endcase
  end

  // the instruction latched in fetch must decode to a known class
  assert property (@(posedge clk) disable iff (reset)
    (state == sDecode) |-> (op inside {opRtype, opLw, opSw, opBeq, opAddi, opJ}))
    else $error("unsupported opcode %b, executed as no-op",
                instr[`MIPS_OP_LSB +: `MIPS_OPCODE_W]);

endmodule

`default_nettype wire

//--- rtl/programCounter.sv
// program counter with next-pc select and branch/jump load enable for the MIPS core
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module programCounter import mipsPkg::*; (
  input  logic  clk,
  input  logic  reset,
  ctrlIf.pc     ctl,
  input  word_t instr,     // jump field source
  input  word_t aluResult, // pc + 4 during fetch
  input  word_t aluOut,    // branch target from decode
  input  logic  zero,
  output word_t pc
);
  logic  pcEn;
  word_t jumpTarget, nextPc;

  assign pcEn       = ctl.pcWrite | (ctl.branch & zero); // beq taken only on equal
  assign jumpTarget = {pc[`MIPS_WORD_W-1 -: 4], instr[`MIPS_JUMP_W-1:0], 2'b00};

  always_comb begin
    case (ctl.pcSrc)
      pcAluOut: nextPc = aluOut;
      pcJump:   nextPc = jumpTarget;
      default:  nextPc = aluResult; // sequential fetch
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= `MIPS_RESET_PC;
    end else if (pcEn) begin
      pc <= nextPc;
    end
  end

  // pc + 4, shifted immediates and jump target all keep the low bits clear
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc %h not word aligned", pc);

endmodule

`default_nettype wire

//--- rtl/datapath.sv
// multicycle MIPS datapath with state registers, operand and write-back muxes, regFile and ALU
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module datapath import mipsPkg::*; (
  input  logic  clk,
  input  logic  reset,
  ctrlIf.dp     ctl,
  input  word_t pc,
  input  word_t readData,  // combinational memory read
  output word_t instr,     // instruction register
  output word_t aluResult,
  output word_t aluOut,    // alu result one cycle later
  output logic  zero,
  output word_t adr,       // memory address
  output word_t writeData  // store data, register B
);
  word_t    memData, regA, regB;
  word_t    rd1, rd2, wd, srcA, srcB;
  word_t    signImm, signImmSh;
  regAddr_t rs, rt, rd, wa;

  assign rs = instr[`MIPS_RS_LSB +: `MIPS_REG_ADDR_W];
  assign rt = instr[`MIPS_RT_LSB +: `MIPS_REG_ADDR_W];
  assign rd = instr[`MIPS_RD_LSB +: `MIPS_REG_ADDR_W];

  assign signImm   = {{(`MIPS_WORD_W - `MIPS_IMM_W){instr[`MIPS_IMM_W-1]}},
                      instr[`MIPS_IMM_W-1:0]};
  assign signImmSh = {signImm[`MIPS_WORD_W-3:0], 2'b00}; // branch offset in bytes

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instr   <= '0;
      memData <= '0;
      regA    <= '0;
      regB    <= '0;
      aluOut  <= '0;
    end else begin
      if (ctl.irWrite) begin
        instr <= readData; // held for the rest of the instruction
      end
      memData <= readData; // free running, used in sMemWb
      regA    <= rd1;
      regB    <= rd2;
      aluOut  <= aluResult;
    end
  end

  assign wa        = ctl.regDst ? rd : rt;
  assign wd        = ctl.memToReg ? memData : aluOut;
  assign adr       = ctl.iorD ? aluOut : pc; // data access or fetch
  assign writeData = regB;
  assign srcA      = ctl.aluSrcA ? regA : pc;

  always_comb begin
    case (ctl.aluSrcB)
      srcBReg:  srcB = regB;
      srcBFour: srcB = word_t'(4); // pc increment
      srcBImm:  srcB = signImm;
      default:  srcB = signImmSh;
    endcase
  end

  regFile regFile_inst (.clk, .we(ctl.regWrite), .ra1(rs), .ra2(rt), .wa, .wd, .rd1, .rd2);
  alu alu_inst (.a(srcA), .b(srcB), .op(ctl.aluCtrl), .y(aluResult), .zero);

  // fetch and writeback are separate FSM states, never the same cycle
  assert property (@(posedge clk) disable iff (reset) !(ctl.irWrite && ctl.regWrite))
    else $error("instruction load during register write");

endmodule

`default_nettype wire

//--- rtl/mipsCore.sv
// top level of the multicycle MIPS core; the memory sits outside on adr/writeData/readData
`default_nettype none
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
  input  logic  clk,
  input  logic  reset,
  output word_t adr,       // shared instruction and data address
  output word_t writeData,
  output logic  memWrite,  // write on rising edge when high
  input  word_t readData   // combinational read of adr
);
  word_t instr, aluResult, aluOut, pc;
  logic  zero;

  ctrlIf ctl ();

  controlFsm controlFsm_inst (
    .clk, .reset, .instr, .ctl(ctl.fsm), .memWrite
  );

  programCounter programCounter_inst (
    .clk, .reset, .ctl(ctl.pc), .instr, .aluResult, .aluOut, .zero, .pc
  );

  datapath datapath_inst (
    .clk, .reset, .ctl(ctl.dp), .pc, .readData,
    .instr, .aluResult, .aluOut, .zero, .adr, .writeData
  );

endmodule

`default_nettype wire

//--- tests/mipsTb.sv
// testbench for mipsCore; owns the shared memory, runs four programs and checks every store
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module mipsTb import mipsPkg::*; ();
  localparam int resetCycles = 10;
  localparam int memWords    = 64;

  logic   clk = 1'b0;
  logic   reset;
  word_t  adr, writeData, readData;
  logic   memWrite;
  word_t  mem [memWords];   // what the core sees
  word_t  image [memWords]; // program image, copied into mem during reset
  int     progPtr;          // next free word while assembling
  int     cyc;              // cycles since reset release
  int     refCycles;        // reference length of the current program
  int     storesSeen;
  integer seed;
  word_t  expAdr [$];       // expected stores, in order
  word_t  expData [$];
  int     expCycle [$];

  mipsCore mipsCore_inst (.clk, .reset, .adr, .writeData, .memWrite, .readData);

  always #2 clk = ~clk; // 4 ns period

  assign readData = mem[adr[7:2]]; // combinational, word addressed

  always @(posedge clk) begin
    if (reset) begin
      mem <= image; // reload program while held in reset
    end else if (memWrite) begin
      mem[adr[7:2]] <= writeData;
    end
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  task automatic checkEq(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic word_t rType(funct_t fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
    return {opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t iType(opcode_t op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jType(int target); // target as word index
    return {opJ, 26'(target)};
  endfunction

  task automatic emit(input word_t w);
    image[progPtr] = w;
    progPtr++;
  endtask

  task automatic clearImage();
    int i;
    for (i = 0; i < memWords; i++) begin
      image[i] = 32'hbad0_0000 | word_t'(i * 4); // fill follows the byte address
    end
    progPtr = 0;
  endtask

  // ISA-level interpreter; queues the expected stores and their cycles
  function automatic void refRun();
    word_t      rf [32];
    word_t      refMem [memWords];
    word_t      ins, a, b, imm, ea, nextPc, pcR;
    logic [5:0] op, fn;
    int         cycle, steps, i;
    bit         done;
    refMem = image;
    for (i = 0; i < 32; i++) begin
      rf[i] = '0;
    end
    pcR   = `MIPS_RESET_PC;
    cycle = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 500) begin
      ins    = refMem[pcR[7:2]];
      op     = ins[31:26];
      fn     = ins[5:0];
      a      = rf[ins[25:21]];
      b      = rf[ins[20:16]];
      imm    = {{16{ins[15]}}, ins[15:0]};
      ea     = a + imm;
      nextPc = pcR + 32'd4;
      case (op)
        opRtype: begin
          case (fn)
            fnAdd:   rf[ins[15:11]] = a + b;
            fnSub:   rf[ins[15:11]] = a - b;
            fnAnd:   rf[ins[15:11]] = a & b;
            fnOr:    rf[ins[15:11]] = a | b;
            fnSlt:   rf[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
          cycle += 4;
        end
        opAddi: begin
          rf[ins[20:16]] = ea;
          cycle += 4;
        end
        opLw: begin
          rf[ins[20:16]] = refMem[ea[7:2]];
          cycle += 5;
        end
        opSw: begin
          expAdr.push_back(ea);
          expData.push_back(b);
          expCycle.push_back(cycle + 3); // fetch, decode, address, write
          refMem[ea[7:2]] = b;
          cycle += 4;
        end
        opBeq: begin
          if (a == b) nextPc = pcR + 32'd4 + {imm[29:0], 2'b00};
          cycle += 3;
        end
        opJ: begin
          nextPc = {pcR[31:28], ins[25:0], 2'b00};
          done   = (nextPc == pcR); // jump to self ends the program
          cycle += 3;
        end
        default: cycle += 2; // no-op
      endcase
      rf[0] = '0;
      pcR   = nextPc;
      steps++;
    end
    refCycles = cycle;
  endfunction

  task automatic buildAluProg();
    int k;
    clearImage();
    emit(iType(opAddi, 5'd1, 5'd0, 16'd25));
    emit(iType(opAddi, 5'd2, 5'd0, 16'hfff9)); // -7
    emit(rType(fnAdd, 5'd3, 5'd1, 5'd2));
    emit(rType(fnSub, 5'd4, 5'd2, 5'd1));
    emit(rType(fnAnd, 5'd5, 5'd1, 5'd2));
    emit(rType(fnOr, 5'd6, 5'd1, 5'd2));
    emit(rType(fnSlt, 5'd7, 5'd2, 5'd1)); // negative less than positive
    emit(rType(fnSlt, 5'd8, 5'd1, 5'd2));
    for (k = 3; k < 9; k++) begin
      emit(iType(opSw, regAddr_t'(k), 5'd0, 16'(128 + 4 * k)));
    end
    emit(jType(progPtr));
  endtask

  task automatic buildMemProg();
    clearImage();
    emit(iType(opAddi, 5'd1, 5'd0, 16'h1234));
    emit(iType(opSw, 5'd1, 5'd0, 16'd160));
    emit(iType(opLw, 5'd2, 5'd0, 16'd160)); // read back what was stored
    emit(iType(opSw, 5'd2, 5'd0, 16'd164));
    emit(iType(opAddi, 5'd0, 5'd0, 16'd55)); // r0 write must be invisible
    emit(iType(opSw, 5'd0, 5'd0, 16'd168));
    emit(iType(opLw, 5'd4, 5'd0, 16'd200)); // untouched fill word
    emit(iType(opSw, 5'd4, 5'd0, 16'd172));
    emit(jType(progPtr));
  endtask

  task automatic buildBranchProg();
    clearImage();
    emit(iType(opAddi, 5'd1, 5'd0, 16'd5));
    emit(iType(opAddi, 5'd2, 5'd0, 16'd5));
    emit(iType(opBeq, 5'd2, 5'd1, 16'd1));  // taken, skips next
    emit(iType(opSw, 5'd1, 5'd0, 16'd128));
    emit(iType(opBeq, 5'd0, 5'd1, 16'd1));  // not taken
    emit(iType(opSw, 5'd2, 5'd0, 16'd132));
    emit(jType(8));
    emit(iType(opSw, 5'd1, 5'd0, 16'd136)); // jumped over
    emit(iType(opAddi, 5'd3, 5'd0, 16'd9));
    emit(iType(opSw, 5'd3, 5'd0, 16'd140));
    emit(jType(progPtr));
  endtask

  task automatic buildRandomProg();
    int          k;
    logic [31:0] rnd;
    regAddr_t    d, s, t;
    clearImage();
    for (k = 1; k < 8; k++) begin
      rnd = $random(seed);
      emit(iType(opAddi, regAddr_t'(k), 5'd0, rnd[15:0])); // define r1..r7
    end
    for (k = 0; k < 40; k++) begin
      rnd = $random(seed);
      d   = {2'b00, rnd[2:0]}; // r0..r7 only, keeps code and data inside 64 words
      s   = {2'b00, rnd[5:3]};
      t   = {2'b00, rnd[8:6]};
      case (int'(rnd[15:9]) % 6)
        0:       emit(iType(opAddi, d, s, rnd[31:16]));
        1:       emit(rType(fnAdd, d, s, t));
        2:       emit(rType(fnSub, d, s, t));
        3:       emit(rType(fnAnd, d, s, t));
        4:       emit(rType(fnOr, d, s, t));
        default: emit(rType(fnSlt, d, s, t));
      endcase
    end
    for (k = 0; k < 8; k++) begin
      emit(iType(opSw, regAddr_t'(k), 5'd0, 16'(224 + 4 * k)));
    end
    emit(jType(progPtr));
  endtask

  task automatic applyReset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  task automatic runProgram(input string name);
    int limit;
    int waited;
    refRun();
    limit  = 2 * refCycles + resetCycles;
    applyReset();
    waited = resetCycles;
    while (expAdr.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > limit) begin
        $display("timeout: program %s still waits for %0d stores after %0d cycles",
                 name, expAdr.size(), waited);
        $display("CHECKS FAILED");
        $fatal(1, "simulation timeout");
      end
    end
    $display("program %s done, %0d stores so far", name, storesSeen);
  endtask

  // samples at the falling edge, half a cycle away from any update
  always @(negedge clk) begin
    if (reset) begin
      checkEq(word_t'(memWrite), '0, "memWrite during reset");
    end else begin
      if (cyc == 0) checkEq(adr, `MIPS_RESET_PC, "first fetch address");
      if (memWrite && expAdr.size() == 0) begin
        $display("store to %h at cycle %0d was not expected", adr, cyc);
        $display("CHECKS FAILED");
        $fatal(1, "unexpected store");
      end else if (memWrite) begin
        checkEq(word_t'(cyc), word_t'(expCycle[0]), "store cycle");
        checkEq(adr, expAdr[0], "store address");
        checkEq(writeData, expData[0], "store data");
        void'(expAdr.pop_front());
        void'(expData.pop_front());
        void'(expCycle.pop_front());
        storesSeen++;
      end
    end
  end

  initial begin
    reset      = 1'b1;
    seed       = 32'h75436c89;
    storesSeen = 0;
    buildAluProg();
    runProgram("alu");
    buildMemProg();
    runProgram("loadStore");
    buildBranchProg();
    runProgram("branch");
    buildRandomProg();
    runProgram("random");
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
rtl/mipsPkg.sv
rtl/ctrlIf.sv
rtl/alu.sv
rtl/regFile.sv
rtl/controlFsm.sv
rtl/programCounter.sv
rtl/datapath.sv
rtl/mipsCore.sv
tests/mipsTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mipsTb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
